// File: BranchPredictor.f
source/BranchPkg.sv
source/BranchTargetBuffer.sv
source/GsharePredictor.sv
source/ReturnStack.sv
source/BackupFile.sv
source/BranchPredictor.sv
verification/BranchPredictorTb.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - source/BranchPkg.sv
  - source/BranchTargetBuffer.sv
  - source/GsharePredictor.sv
  - source/ReturnStack.sv
  - source/BackupFile.sv
  - source/BranchPredictor.sv
  - target: test
    files:
      - verification/BranchPredictorTb.sv

// File: verification/BranchPredictorTb.sv
`timescale 1ns/10ps
`default_nettype none

module BranchPredictorTb;
    import BranchPkg::*;

    localparam logic [30:0] ENTRY_POINT = 31'h0000_0400;
    localparam int CLK_PERIOD = 40;
    // Reset, counter sweep and the five tests stay well below this
    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk;
    logic            rst;
    logic            pcValid;
    FetchID_t        fetchID;
    logic [30:0]     pc;
    PredBranch       predBr;
    RetStackIdx_t    rIdx;
    DecodeBranchProv mispr;
    BTUpdate         btUpdate;
    BPUpdate         bpUpdate;

    integer       seed;
    int           errors;
    int           checks;
    FetchID_t     callFid;
    RetStackIdx_t savedRIdx [16];

    BranchPredictor #(
        .BTB_ENTRIES   (32),
        .GSHARE_ENTRIES(256),
        .ENTRY_POINT   (ENTRY_POINT)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .pcValid (pcValid),
        .fetchID (fetchID),
        .pc      (pc),
        .predBr  (predBr),
        .rIdx    (rIdx),
        .mispr   (mispr),
        .btUpdate(btUpdate),
        .bpUpdate(bpUpdate)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] observed,
                              input logic [31:0] expected);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, observed, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    // Random upper bits, chosen BTB index, offset zero
    function automatic logic [30:0] randomBlock(input logic [4:0] idx);
        logic [31:0] r;
        r = $random(seed);
        return {r[23:0], idx, 2'b00};
    endfunction

    // Ends the cycle; remembers the stack index the backup file stores
    task automatic advance();
        logic wasValid;
        wasValid = pcValid;
        if (pcValid) begin
            savedRIdx[fetchID] = rIdx;
        end
        @(negedge clk);
        if (wasValid) begin
            fetchID = fetchID + 1'b1;
        end
    endtask

    task automatic trainTarget(input logic [30:0] src, input BranchKind kind,
                               input logic [30:0] dst);
        btUpdate.valid = 1'b1;
        btUpdate.src   = src;
        btUpdate.kind  = kind;
        btUpdate.dst   = dst;
        advance();
        btUpdate = '0;
    endtask

    // Mispredict to dst, then accept one fetch at dst
    task automatic redirect(input logic [30:0] dst, input FetchID_t fid,
                            input RetStackAction retAct);
        pcValid         = 1'b0;
        mispr.taken     = 1'b1;
        mispr.fetchID   = fid;
        mispr.fetchOffs = 2'd0;
        mispr.dst       = dst;
        mispr.retAct    = retAct;
        mispr.histAct   = HIST_NONE;
        advance();
        mispr = '0;
        checkValue("pc", pc, dst);
        checkValue("predBr.valid", predBr.valid, 1'b0);
        pcValid = 1'b1;
        advance();
    endtask

    task automatic sequentialFetch();
        int          errorsBefore;
        logic [30:0] expectPc;
        errorsBefore = errors;
        checkValue("pc", pc, ENTRY_POINT);
        checkValue("predBr.valid", predBr.valid, 1'b0);
        expectPc = ENTRY_POINT;
        pcValid  = 1'b1;
        repeat (8) begin
            advance();
            expectPc = expectPc + 31'd4;
            checkValue("pc", pc, expectPc);
            checkValue("predBr.valid", predBr.valid, 1'b0);
        end
        pcValid = 1'b0;
        reportTest("sequential fetch", errorsBefore);
    endtask

    task automatic trainedJump();
        int          errorsBefore;
        logic [30:0] block;
        logic [30:0] target;
        FetchOff_t   offs;
        errorsBefore = errors;
        block  = randomBlock(5'd3);
        target = randomBlock(5'd17);
        offs   = FetchOff_t'($random(seed));
        trainTarget({block[30:2], offs}, BR_JUMP, target);
        redirect(block, fetchID - 1'b1, RET_NONE);
        pcValid = 1'b0;
        checkValue("predBr.valid", predBr.valid, 1'b1);
        checkValue("predBr.kind", predBr.kind, BR_JUMP);
        checkValue("predBr.taken", predBr.taken, 1'b1);
        checkValue("predBr.offs", predBr.offs, offs);
        checkValue("predBr.dst", predBr.dst, target);
        checkValue("pc", pc, target);
        reportTest("trained jump", errorsBefore);
    endtask

    task automatic callAndReturn();
        int           errorsBefore;
        logic [30:0]  callBlock;
        logic [30:0]  retBlock;
        logic [30:0]  retAddr;
        FetchOff_t    callOffs;
        RetStackIdx_t startIdx;
        RetStackIdx_t pushedIdx;
        errorsBefore = errors;
        callBlock = randomBlock(5'd7);
        retBlock  = randomBlock(5'd12);
        callOffs  = FetchOff_t'($random(seed));
        retAddr   = callBlock + 31'(callOffs) + 31'd1;
        // The call lands directly on the block holding the return
        trainTarget({callBlock[30:2], callOffs}, BR_CALL, retBlock);
        trainTarget({retBlock[30:2], FetchOff_t'($random(seed))}, BR_RET, 31'h0);
        redirect(callBlock, fetchID - 1'b1, RET_NONE);
        startIdx  = rIdx;
        pushedIdx = startIdx + 1'b1;
        checkValue("predBr.valid", predBr.valid, 1'b1);
        checkValue("predBr.kind", predBr.kind, BR_CALL);
        checkValue("pc", pc, retBlock);
        callFid = fetchID;
        advance();
        checkValue("rIdx", rIdx, pushedIdx);
        checkValue("predBr.kind", predBr.kind, BR_RET);
        checkValue("pc", pc, retAddr);
        advance();
        pcValid = 1'b0;
        checkValue("rIdx", rIdx, startIdx);
        reportTest("call and return", errorsBefore);
    endtask

    task automatic directionTraining();
        int          errorsBefore;
        logic [30:0] block;
        logic [30:0] target;
        FetchOff_t   offs;
        FetchID_t    zeroFid;
        errorsBefore = errors;
        block  = randomBlock(5'd20);
        target = randomBlock(5'd25);
        offs   = FetchOff_t'($random(seed));
        trainTarget({block[30:2], offs}, BR_COND, target);
        // No conditional branch was predicted so far, so history is still zero here
        zeroFid = fetchID;
        redirect(block, fetchID - 1'b1, RET_NONE);
        pcValid = 1'b0;
        checkValue("predBr.kind", predBr.kind, BR_COND);
        checkValue("predBr.taken", predBr.taken, 1'b0);
        checkValue("pc", pc, block + 31'd4);
        bpUpdate.valid       = 1'b1;
        bpUpdate.fetchID     = zeroFid;
        bpUpdate.pc          = {block[30:2], offs};
        bpUpdate.branchTaken = 1'b1;
        repeat (2) begin
            advance();
        end
        bpUpdate = '0;
        advance();
        redirect(block, zeroFid, RET_NONE);
        pcValid = 1'b0;
        checkValue("predBr.kind", predBr.kind, BR_COND);
        checkValue("predBr.taken", predBr.taken, 1'b1);
        checkValue("pc", pc, target);
        reportTest("direction training", errorsBefore);
    endtask

    task automatic mispredictRecovery();
        int           errorsBefore;
        logic [30:0]  dst;
        RetStackIdx_t expectIdx;
        errorsBefore = errors;
        dst       = randomBlock(5'd27);
        dst[1:0]  = FetchOff_t'($random(seed));
        expectIdx = savedRIdx[callFid] - 1'b1;
        redirect(dst, callFid, RET_POP);
        pcValid = 1'b0;
        checkValue("rIdx", rIdx, expectIdx);
        reportTest("mispredict recovery", errorsBefore);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        pcValid  = 1'b0;
        fetchID  = '0;
        mispr    = '0;
        btUpdate = '0;
        bpUpdate = '0;
        seed     = 32'hd7fc_d466;
        errors   = 0;
        checks   = 0;
        callFid  = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        // Counter sweep of 256 cycles
        repeat (260) @(negedge clk);
        sequentialFetch();
        trainedJump();
        callAndReturn();
        directionTraining();
        mispredictRecovery();
        $display("5 tests run, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/BranchPredictor.sv
`timescale 1ns/10ps
`default_nettype none

module BranchPredictor #(
    parameter int          BTB_ENTRIES    = 32,
    parameter int          GSHARE_ENTRIES = 256,
    parameter logic [30:0] ENTRY_POINT    = 31'h0000_0400
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              pcValid,
    input  wire BranchPkg::FetchID_t         fetchID,
    output logic [30:0]                      pc,
    output BranchPkg::PredBranch             predBr,
    output BranchPkg::RetStackIdx_t          rIdx,
    input  wire BranchPkg::DecodeBranchProv  mispr,
    input  wire BranchPkg::BTUpdate          btUpdate,
    input  wire BranchPkg::BPUpdate          bpUpdate
);
    import BranchPkg::*;

    localparam int HIST_W = $bits(BHist_t);

    typedef struct packed {
        logic          valid;
        FetchOff_t     fetchOffs;
        RetStackAction retAct;
        HistoryAction  histAct;
    } Recovery;

    logic [30:0]  pcReg;
    logic         ignorePred;
    BHist_t       history;
    BHist_t       lookupHistory;
    BHist_t       recHistory;
    RetStackIdx_t recRIdx;
    Recovery      recovery;
    BPBackup      recBackup;
    BPUpdate      update;
    BHist_t       updHistory;

    BPBackup     bpBackup;
    BPBackup     bpRecRead;
    BPBackup     bpUpdRead;
    logic        btbHit;
    BranchKind   btbKind;
    FetchOff_t   btbOffs;
    logic [30:0] btbDst;
    logic        gsTaken;
    logic [30:0] retTop;
    logic        retPush;
    logic        retPop;
    logic [30:0] retAddr;

    // Prediction for the block in pcReg; the first cycle after a redirect has none
    always_comb begin
        predBr = '0;
        pc     = {pcReg[30:2] + 29'd1, 2'b00};
        if (ignorePred) begin
            pc = pcReg;
        end else if (btbHit && btbOffs >= pcReg[1:0]) begin
            predBr.valid = 1'b1;
            predBr.kind  = btbKind;
            predBr.offs  = btbOffs;
            predBr.dst   = (btbKind == BR_RET) ? retTop : btbDst;
            predBr.taken = (btbKind == BR_COND) ? gsTaken : 1'b1;
            if (predBr.taken) begin
                pc = predBr.dst;
            end
        end
    end

    assign retPush = pcValid && !mispr.taken && predBr.valid && predBr.kind == BR_CALL;
    assign retPop  = pcValid && !mispr.taken && predBr.valid && predBr.kind == BR_RET;
    assign retAddr = {pcReg[30:2], predBr.offs} + 31'd1;

    always_comb begin
        bpBackup.history   = history;
        bpBackup.rIdx      = rIdx;
        bpBackup.pred      = predBr.valid && predBr.kind == BR_COND;
        bpBackup.predTaken = predBr.taken;
        bpBackup.predOffs  = predBr.offs;
    end

    // Rebuild history up to and including the mispredicted branch
    always_comb begin
        recHistory = recBackup.history;
        case (recovery.histAct)
            HIST_WRITE_0: recHistory = {recHistory[HIST_W-2:0], 1'b0};
            HIST_WRITE_1: recHistory = {recHistory[HIST_W-2:0], 1'b1};
            default: begin
                if (recBackup.pred && recBackup.predOffs <= recovery.fetchOffs) begin
                    recHistory = {recHistory[HIST_W-2:0], recBackup.predTaken};
                end
            end
        endcase
        if (recovery.histAct == HIST_APPEND_1) begin
            recHistory = {recHistory[HIST_W-2:0], 1'b1};
        end
    end

    always_comb begin
        recRIdx = recBackup.rIdx;
        case (recovery.retAct)
            RET_PUSH: recRIdx = recBackup.rIdx + 1'b1;
            RET_POP:  recRIdx = recBackup.rIdx - 1'b1;
            default:  recRIdx = recBackup.rIdx;
        endcase
    end

    always_comb begin
        lookupHistory = history;
        if (recovery.valid) begin
            lookupHistory = recHistory;
        end else if (predBr.valid && predBr.kind == BR_COND) begin
            lookupHistory = {history[HIST_W-2:0], predBr.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (mispr.taken) begin
            recovery.fetchOffs <= mispr.fetchOffs;
            recovery.retAct    <= mispr.retAct;
            recovery.histAct   <= mispr.histAct;
            recBackup          <= bpRecRead;
        end
        if (bpUpdate.valid) begin
            update     <= bpUpdate;
            updHistory <= bpUpdRead.history;
        end
        if (rst) begin
            pcReg          <= ENTRY_POINT;
            ignorePred     <= 1'b1;
            history        <= '0;
            recovery.valid <= 1'b0;
            update.valid   <= 1'b0;
        end else begin
            recovery.valid <= mispr.taken;
            update.valid   <= bpUpdate.valid;
            if (pcValid || recovery.valid) begin
                history <= lookupHistory;
            end
            if (mispr.taken) begin
                pcReg      <= mispr.dst;
                ignorePred <= 1'b1;
            end else if (pcValid) begin
                pcReg      <= pc;
                ignorePred <= 1'b0;
            end
        end
    end

    BranchTargetBuffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) btb (
        .clk        (clk),
        .rst        (rst),
        .lookupValid(pcValid),
        .lookupPc   (pc),
        .hit        (btbHit),
        .hitKind    (btbKind),
        .hitOffs    (btbOffs),
        .hitDst     (btbDst),
        .update     (btUpdate)
    );

    GsharePredictor #(
        .GSHARE_ENTRIES(GSHARE_ENTRIES)
    ) gshare (
        .clk         (clk),
        .rst         (rst),
        .predValid   (pcValid),
        .predAddr    (pc),
        .predHistory (lookupHistory),
        .predTaken   (gsTaken),
        .writeValid  (update.valid),
        .writeAddr   (update.pc),
        .writeHistory(updHistory),
        .writeTaken  (update.branchTaken)
    );

    ReturnStack retStack (
        .clk       (clk),
        .rst       (rst),
        .push      (retPush),
        .pushAddr  (retAddr),
        .pop       (retPop),
        .top       (retTop),
        .curIdx    (rIdx),
        .restore   (recovery.valid),
        .restoreIdx(recRIdx)
    );

    BackupFile backupFile (
        .clk   (clk),
        .we    (pcValid),
        .waddr (fetchID),
        .wdata (bpBackup),
        .raddr0(mispr.fetchID),
        .rdata0(bpRecRead),
        .raddr1(bpUpdate.fetchID),
        .rdata1(bpUpdRead)
    );

endmodule

`default_nettype wire

// File: source/BackupFile.sv
`timescale 1ns/10ps
`default_nettype none

module BackupFile (
    input  wire                      clk,
    input  wire                      we,
    input  wire BranchPkg::FetchID_t waddr,
    input  wire BranchPkg::BPBackup  wdata,
    input  wire BranchPkg::FetchID_t raddr0,
    output BranchPkg::BPBackup       rdata0,
    input  wire BranchPkg::FetchID_t raddr1,
    output BranchPkg::BPBackup       rdata1
);
    import BranchPkg::*;

    // One entry per fetch ID in flight
    BPBackup entries [2 ** $bits(FetchID_t)];

    always_ff @(posedge clk) begin
        if (we) begin
            entries[waddr] <= wdata;
        end
    end

    assign rdata0 = entries[raddr0];
    assign rdata1 = entries[raddr1];

endmodule

`default_nettype wire

// File: source/ReturnStack.sv
`timescale 1ns/10ps
`default_nettype none

module ReturnStack (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire [30:0]                   pushAddr,
    input  wire                          pop,
    output logic [30:0]                  top,
    output BranchPkg::RetStackIdx_t      curIdx,
    input  wire                          restore,
    input  wire BranchPkg::RetStackIdx_t restoreIdx
);
    import BranchPkg::*;

    localparam int DEPTH = 2 ** $bits(RetStackIdx_t);

    logic [30:0]  entries [DEPTH];
    RetStackIdx_t pushIdx;
    RetStackIdx_t popIdx;

    // Index wraps around, oldest entries get overwritten
    assign pushIdx = curIdx + 1'b1;
    assign popIdx  = curIdx - 1'b1;
    assign top     = entries[curIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            curIdx <= '0;
        end else if (restore) begin
            curIdx <= restoreIdx;
        end else if (push) begin
            curIdx <= pushIdx;
        end else if (pop) begin
            curIdx <= popIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !restore) begin
            entries[pushIdx] <= pushAddr;
        end
    end

    // One predicted branch per block, so never both
    pushPopExclusive: assert property (@(posedge clk) disable iff (rst)
        !(push && pop));

endmodule

`default_nettype wire

// File: source/GsharePredictor.sv
`timescale 1ns/10ps
`default_nettype none

module GsharePredictor #(
    parameter int GSHARE_ENTRIES = 256
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    predValid,
    input  wire [30:0]             predAddr,
    input  wire BranchPkg::BHist_t predHistory,
    output logic                   predTaken,
    input  wire                    writeValid,
    input  wire [30:0]             writeAddr,
    input  wire BranchPkg::BHist_t writeHistory,
    input  wire                    writeTaken
);
    localparam int IDX_W = $clog2(GSHARE_ENTRIES);

    logic [1:0] counters [GSHARE_ENTRIES];

    logic             initBusy;
    logic [IDX_W-1:0] initIdx;
    logic [IDX_W-1:0] predIdx;
    logic [IDX_W-1:0] writeIdx;
    logic [1:0]       writeCtr;
    logic [1:0]       nextCtr;

    assign predIdx  = predAddr[IDX_W+1:2] ^ IDX_W'(predHistory);
    assign writeIdx = writeAddr[IDX_W+1:2] ^ IDX_W'(writeHistory);

    // Saturating two-bit counter step
    always_comb begin
        writeCtr = counters[writeIdx];
        nextCtr  = writeCtr;
        if (writeTaken && writeCtr != 2'd3) begin
            nextCtr = writeCtr + 2'd1;
        end else if (!writeTaken && writeCtr != 2'd0) begin
            nextCtr = writeCtr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (initBusy) begin
            counters[initIdx] <= 2'd1;
        end else if (writeValid) begin
            counters[writeIdx] <= nextCtr;
        end
        if (predValid) begin
            predTaken <= counters[predIdx][1];
        end
    end

    // Sweep all counters to weakly not-taken after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            initBusy <= 1'b1;
            initIdx  <= '0;
        end else if (initBusy) begin
            initIdx <= initIdx + 1'b1;
            if (initIdx == IDX_W'(GSHARE_ENTRIES - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

    noLookupDuringInit: assert property (@(posedge clk) disable iff (rst)
        initBusy |-> !predValid);

endmodule

`default_nettype wire

// File: source/BranchTargetBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module BranchTargetBuffer #(
    parameter int BTB_ENTRIES = 32
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  lookupValid,
    input  wire [30:0]           lookupPc,
    output logic                 hit,
    output BranchPkg::BranchKind hitKind,
    output BranchPkg::FetchOff_t hitOffs,
    output logic [30:0]          hitDst,
    input  wire BranchPkg::BTUpdate update
);
    import BranchPkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 29 - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        FetchOff_t        offs;
        BranchKind        kind;
        logic [30:0]      dst;
    } BtbEntry;

    BtbEntry                entries [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] entryValid;

    logic [IDX_W-1:0] lookupIdx;
    logic [TAG_W-1:0] lookupTag;
    logic [IDX_W-1:0] updateIdx;
    BtbEntry          newEntry;

    BtbEntry          readEntry;
    logic             readValid;
    logic [TAG_W-1:0] readTag;

    // Entry selected by the low block address bits
    assign lookupIdx = lookupPc[IDX_W+1:2];
    assign lookupTag = lookupPc[30:IDX_W+2];
    assign updateIdx = update.src[IDX_W+1:2];

    always_comb begin
        newEntry.tag  = update.src[30:IDX_W+2];
        newEntry.offs = update.src[1:0];
        newEntry.kind = update.kind;
        newEntry.dst  = update.dst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            readValid  <= 1'b0;
        end else begin
            if (update.valid) begin
                entryValid[updateIdx] <= 1'b1;
            end
            if (lookupValid) begin
                readValid <= entryValid[lookupIdx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            entries[updateIdx] <= newEntry;
        end
        if (lookupValid) begin
            readEntry <= entries[lookupIdx];
            readTag   <= lookupTag;
        end
    end

    assign hit     = readValid && (readEntry.tag == readTag);
    assign hitKind = readEntry.kind;
    assign hitOffs = readEntry.offs;
    assign hitDst  = readEntry.dst;

    // Trained entries must carry a known kind
    updateKindKnown: assert property (@(posedge clk) disable iff (rst)
        update.valid |-> !$isunknown(update.kind));

endmodule

`default_nettype wire

// File: source/BranchPkg.sv
`default_nettype none

package BranchPkg;

    // Halfword offset inside a four-halfword fetch block
    typedef logic [1:0] FetchOff_t;
    typedef logic [3:0] FetchID_t;
    typedef logic [7:0] BHist_t;
    typedef logic [2:0] RetStackIdx_t;

    typedef enum logic [1:0] {
        BR_COND,
        BR_JUMP,
        BR_CALL,
        BR_RET
    } BranchKind;

    typedef enum logic [1:0] {
        RET_NONE,
        RET_PUSH,
        RET_POP
    } RetStackAction;

    typedef enum logic [1:0] {
        HIST_NONE,
        HIST_WRITE_0,
        HIST_WRITE_1,
        HIST_APPEND_1
    } HistoryAction;

    typedef struct packed {
        logic        valid;
        BranchKind   kind;
        logic        taken;
        FetchOff_t   offs;
        logic [30:0] dst;
    } PredBranch;

    typedef struct packed {
        logic        valid;
        logic [30:0] src;
        BranchKind   kind;
        logic [30:0] dst;
    } BTUpdate;

    typedef struct packed {
        logic          taken;
        FetchID_t      fetchID;
        FetchOff_t     fetchOffs;
        logic [30:0]   dst;
        RetStackAction retAct;
        HistoryAction  histAct;
    } DecodeBranchProv;

    typedef struct packed {
        logic        valid;
        FetchID_t    fetchID;
        logic [30:0] pc;
        logic        branchTaken;
    } BPUpdate;

    // State before the block's own prediction, plus that prediction
    typedef struct packed {
        BHist_t       history;
        RetStackIdx_t rIdx;
        logic         pred;
        logic         predTaken;
        FetchOff_t    predOffs;
    } BPBackup;

endpackage

`default_nettype wire
